//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert -f exec_unit.f --top-module tb_exec_unit -Mdir obj_dir -o tb_exec_unit
	./obj_dir/tb_exec_unit > sim.log 2>&1 || true
	cat sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(PERIOD_NS / 2) clk = ~clk;   // free running, stopped by $finish
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module tb_exec_unit;
    import exec_pkg::*;

    localparam int      TIMEOUT_CYCLES = 200;
    localparam int      DEPTH          = `EXEC_QUEUE_DEPTH;
    localparam int      READY_HIGH     = 0;
    localparam int      READY_LOW      = 1;
    localparam int      READY_RANDOM   = 2;
    localparam opcode_t OPC_OP         = 7'b0110011;
    localparam opcode_t OPC_IMM        = 7'b0010011;
    localparam opcode_t OPC_BRANCH     = 7'b1100011;
    localparam funct7_t F7_ALT         = 7'b0100000;
    localparam word_t   SIGN_BIT       = {1'b1, {(`EXEC_XLEN-1){1'b0}}};

    typedef struct packed {
        word_t result;
        logic  zero;
        logic  cond_jump;
        logic  err;
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    opcode_t     opcode;
    funct3_t     funct3;
    funct7_t     funct7;
    word_t       rs1_val;
    word_t       rs2_val;
    word_t       imm;
    logic        out_ready;
    logic        in_ready;
    logic        out_valid;
    word_t       result;
    logic        zero;
    logic        cond_jump;
    logic        err;

    expect_t     exp_q[$];          // oldest accepted instruction at the front
    logic [31:0] stim_state    = 32'd78;
    logic [31:0] ready_state   = ~32'd78;   // second stream for out_ready
    int          ready_mode    = READY_HIGH;
    int          mismatch_errs = 0;
    int          other_errs    = 0;
    int          timeout_errs  = 0;
    int          sent          = 0;
    int          checked       = 0;

    // next instruction as filled in by the generators
    opcode_t     nxt_opc;
    funct3_t     nxt_f3;
    funct7_t     nxt_f7;
    word_t       nxt_a;
    word_t       nxt_b;
    word_t       nxt_imm;

    tb_clock_gen #(.PERIOD_NS(20)) clk_gen (.clk(clk));

    exec_unit uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .opcode    (opcode),
        .funct3    (funct3),
        .funct7    (funct7),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .imm       (imm),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .result    (result),
        .zero      (zero),
        .cond_jump (cond_jump),
        .err       (err)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] stim_rand();
        stim_state = lcg_step(stim_state);
        return stim_state ^ (stim_state >> 16);   // fold high bits into the weak low ones
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{(`EXEC_XLEN-12){v[11]}}, v};
    endfunction

    // corner values show up often enough to hit sign and carry cases
    function automatic word_t rand_operand();
        logic [31:0] r;
        r = stim_rand();
        case (r[30:28])
            3'd0:    return '0;
            3'd1:    return SIGN_BIT;
            3'd2:    return '1;
            3'd3:    return SIGN_BIT - 1'b1;
            default: return stim_rand();
        endcase
    endfunction

    // expected outputs from the RV32I rules of the execute stage
    function automatic expect_t exp_result(input opcode_t opc, input funct3_t f3,
                                           input funct7_t f7, input word_t a,
                                           input word_t rs2, input word_t imm_v);
        expect_t    e;
        word_t      b;
        logic [4:0] sh;
        logic       bad;
        e   = '0;
        bad = 1'b0;
        b   = (opc == OPC_IMM) ? imm_v : rs2;
        sh  = b[4:0];
        if (opc == OPC_OP || opc == OPC_IMM)
        begin
            if (opc == OPC_OP)
                bad = (f7 != 7'b0 && f7 != F7_ALT);
            else if (f3 == 3'b001)
                bad = (f7 != 7'b0);
            else if (f3 == 3'b101)
                bad = (f7 != 7'b0 && f7 != F7_ALT);
            case (f3)
                3'b000:
                begin
                    if (opc == OPC_OP && f7 == F7_ALT)
                        e.result = a - b;
                    else
                        e.result = a + b;
                end
                3'b001:  e.result = a << sh;
                3'b010:  e.result[0] = ($signed(a) < $signed(b));
                3'b011:  e.result[0] = (a < b);
                3'b100:  e.result = a ^ b;
                3'b101:
                begin
                    if (f7 == F7_ALT)
                        e.result = $signed(a) >>> sh;
                    else
                        e.result = a >> sh;
                end
                3'b110:  e.result = a | b;
                default: e.result = a & b;
            endcase
        end
        else if (opc == OPC_BRANCH)
        begin
            case (f3)
                3'b000:  e.cond_jump = (a == b);
                3'b001:  e.cond_jump = (a != b);
                3'b100:  e.cond_jump = ($signed(a) < $signed(b));
                3'b101:  e.cond_jump = ($signed(a) >= $signed(b));
                3'b110:  e.cond_jump = (a < b);
                3'b111:  e.cond_jump = (a >= b);
                default: bad = 1'b1;
            endcase
        end
        else
        begin
            bad = 1'b1;
        end
        if (bad)
        begin
            e.result    = '0;
            e.cond_jump = 1'b0;
        end
        e.err  = bad;
        e.zero = (e.result == '0);
        return e;
    endfunction

    task automatic finish_run();
        $display("errors: %0d mismatch, %0d other, %0d timeout (%0d sent, %0d checked)",
                 mismatch_errs, other_errs, timeout_errs, sent, checked);
        if (mismatch_errs + other_errs + timeout_errs == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    endtask

    task automatic check_field(input string name, input word_t exp_v, input word_t act_v);
        assert (act_v == exp_v)
        else
        begin
            $display("MISMATCH %s: expected 0x%h, actual 0x%h", name, exp_v, act_v);
            mismatch_errs++;
        end
    endtask

    task automatic record_accept();
        exp_q.push_back(exp_result(opcode, funct3, funct7, rs1_val, rs2_val, imm));
        sent++;
    endtask

    task automatic present_next();
        @(negedge clk);
        opcode   = nxt_opc;
        funct3   = nxt_f3;
        funct7   = nxt_f7;
        rs1_val  = nxt_a;
        rs2_val  = nxt_b;
        imm      = nxt_imm;
        in_valid = 1'b1;
    endtask

    // fields stay put until the edge where in_ready is seen high
    task automatic wait_accept();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!in_ready && cycles < TIMEOUT_CYCLES)
        begin
            cycles++;
            @(posedge clk);
        end
        if (!in_ready)
        begin
            $display("ERROR: instruction not accepted within %0d cycles", TIMEOUT_CYCLES);
            timeout_errs++;
            finish_run();
        end
        else
        begin
            record_accept();
        end
    endtask

    task automatic send_next();
        present_next();
        wait_accept();
    endtask

    task automatic drain_outputs();
        int cycles;
        cycles = 0;
        @(negedge clk);
        in_valid = 1'b0;
        while (exp_q.size() != 0 && cycles < TIMEOUT_CYCLES)
        begin
            cycles++;
            @(negedge clk);
        end
        if (exp_q.size() != 0)
        begin
            $display("ERROR: %0d results still missing after %0d cycles", exp_q.size(),
                     TIMEOUT_CYCLES);
            timeout_errs++;
            finish_run();
        end
    endtask

    task automatic set_ready_mode(input int mode);
        @(posedge clk);
        ready_mode = mode;   // takes effect on the next falling edge
    endtask

    task automatic gen_alu();
        logic [31:0] r;
        r      = stim_rand();
        nxt_f3 = r[18:16];
        nxt_a  = rand_operand();
        nxt_b  = rand_operand();
        if (r[20])
        begin
            nxt_opc = OPC_OP;
            nxt_f7  = (r[21] && (nxt_f3 == 3'b000 || nxt_f3 == 3'b101)) ? F7_ALT : 7'b0;
            nxt_imm = rand_operand();
        end
        else
        begin
            nxt_opc = OPC_IMM;
            nxt_f7  = r[27:21];   // decoder passes imm[11:5] as funct7
            if (nxt_f3 == 3'b001 || nxt_f3 == 3'b101)
                nxt_f7 = (r[22] && nxt_f3 == 3'b101) ? F7_ALT : 7'b0;
            nxt_imm = sext12({nxt_f7, r[4:0]});
        end
    endtask

    task automatic gen_branch();
        logic [31:0] r;
        r       = stim_rand();
        nxt_opc = OPC_BRANCH;
        nxt_f3  = r[18:16];
        if (nxt_f3 == 3'b010 || nxt_f3 == 3'b011)
            nxt_f3 = nxt_f3 ^ 3'b100;   // fold the undefined codes onto the unsigned compares
        nxt_f7  = r[26:20];
        nxt_a   = rand_operand();
        nxt_imm = rand_operand();
        case (r[29:28])
            2'd0:    nxt_b = nxt_a;
            2'd1:    nxt_b = nxt_a ^ SIGN_BIT;   // same magnitude bits, opposite sign
            default: nxt_b = rand_operand();
        endcase
    endtask

    task automatic gen_invalid();
        logic [31:0] r;
        r       = stim_rand();
        nxt_f3  = r[18:16];
        nxt_f7  = r[26:20];
        nxt_a   = rand_operand();
        nxt_b   = rand_operand();
        nxt_imm = rand_operand();
        case (r[30:28])
            3'd0:    nxt_opc = 7'b0000011;   // load
            3'd1:    nxt_opc = 7'b0100011;   // store
            3'd2:    nxt_opc = r[8] ? 7'b1101111 : 7'b1100111;   // jal, jalr
            3'd3:    nxt_opc = r[8] ? 7'b0110111 : 7'b0010111;   // lui, auipc
            3'd4:
            begin
                nxt_opc = OPC_BRANCH;
                nxt_f3  = {2'b01, r[9]};
            end
            3'd5:
            begin
                nxt_opc = OPC_OP;
                if (nxt_f7 == 7'b0 || nxt_f7 == F7_ALT)
                    nxt_f7 = nxt_f7 | 7'b0000001;
            end
            default:
            begin
                // shift-immediates with upper bits that name no shift
                nxt_opc = OPC_IMM;
                nxt_f3  = r[9] ? 3'b001 : 3'b101;
                if (nxt_f3 == 3'b001 && nxt_f7 == 7'b0)
                    nxt_f7 = F7_ALT;
                else if (nxt_f3 == 3'b101 && (nxt_f7 == 7'b0 || nxt_f7 == F7_ALT))
                    nxt_f7 = nxt_f7 | 7'b0000010;
                nxt_imm = sext12({nxt_f7, r[14:10]});
            end
        endcase
    endtask

    initial
    begin
        out_ready = 1'b1;
        forever
        begin
            @(negedge clk);
            if (ready_mode == READY_RANDOM)
            begin
                ready_state = lcg_step(ready_state);
                out_ready   = (ready_state[31:30] != 2'b00);   // high three cycles in four
            end
            else
            begin
                out_ready = (ready_mode == READY_HIGH);
            end
        end
    end

    // scoreboard pops one tuple per output transfer
    always @(posedge clk)
    begin
        expect_t e;
        if (rst_n && out_valid && out_ready)
        begin
            assert (exp_q.size() != 0)
            else
            begin
                $display("ERROR: output transfer with no instruction outstanding");
                other_errs++;
            end
            if (exp_q.size() != 0)
            begin
                e = exp_q.pop_front();
                check_field("result", e.result, result);
                check_field("zero", word_t'(e.zero), word_t'(zero));
                check_field("cond_jump", word_t'(e.cond_jump), word_t'(cond_jump));
                check_field("err", word_t'(e.err), word_t'(err));
                checked++;
            end
        end
    end

    initial
    begin
        int   lat;
        int   held;
        logic stalled;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        opcode   = '0;
        funct3   = '0;
        funct7   = '0;
        rs1_val  = '0;
        rs2_val  = '0;
        imm      = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // one idle cycle after reset and then a single ADD for the latency
        @(posedge clk);
        assert (in_ready && !out_valid)
        else
        begin
            $display("ERROR: after reset in_ready=%b out_valid=%b", in_ready, out_valid);
            other_errs++;
        end
        nxt_opc = OPC_OP;
        nxt_f3  = 3'b000;
        nxt_f7  = 7'b0;
        nxt_a   = 32'h1234_5678;
        nxt_b   = 32'h0edc_ba98;
        nxt_imm = '0;
        send_next();
        @(negedge clk);
        in_valid = 1'b0;
        lat      = 1;
        while (!out_valid && lat < TIMEOUT_CYCLES)
        begin
            @(negedge clk);
            lat++;
        end
        if (!out_valid)
        begin
            $display("ERROR: no result for the first ADD within %0d cycles", TIMEOUT_CYCLES);
            timeout_errs++;
            finish_run();
        end
        else
        begin
            assert (lat == 2)
            else
            begin
                $display("ERROR: first ADD result took %0d cycles instead of 2", lat);
                other_errs++;
            end
        end
        drain_outputs();

        set_ready_mode(READY_RANDOM);
        repeat (200)
        begin
            gen_alu();
            send_next();
        end
        repeat (60)
        begin
            gen_branch();
            send_next();
        end
        repeat (60)
        begin
            gen_invalid();
            send_next();
        end
        drain_outputs();

        // under back-pressure the queue and then the slot fill up
        set_ready_mode(READY_LOW);
        held    = 0;
        stalled = 1'b0;
        while (!stalled && held <= 2 * DEPTH)
        begin
            gen_alu();
            present_next();
            @(posedge clk);
            if (in_ready)
            begin
                record_accept();
                held++;
            end
            else
            begin
                stalled = 1'b1;
            end
        end
        assert (held == DEPTH + 1)
        else
        begin
            $display("ERROR: %0d items accepted under back-pressure, expected %0d",
                     held, DEPTH + 1);
            other_errs++;
        end
        repeat (3)
        begin
            @(posedge clk);
            assert (!in_ready)
            else
            begin
                $display("ERROR: in_ready rose while the output was stalled");
                other_errs++;
            end
        end
        set_ready_mode(READY_HIGH);
        wait_accept();   // the held item enters once the queue moves
        drain_outputs();

        set_ready_mode(READY_RANDOM);
        repeat (120)
        begin
            case (stim_rand() & 32'd3)
                32'd2:   gen_branch();
                32'd3:   gen_invalid();
                default: gen_alu();
            endcase
            send_next();
        end
        drain_outputs();

        set_ready_mode(READY_HIGH);
        repeat (4)
        begin
            @(negedge clk);
            assert (!out_valid)
            else
            begin
                $display("ERROR: output valid after every result was taken");
                other_errs++;
            end
        end
        finish_run();
    end

endmodule

`default_nettype wire

//--- exec_unit.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/exec_pkg.sv
rtl/operand_stage.sv
rtl/alu_control_unit.sv
rtl/alu.sv
rtl/result_queue.sv
rtl/exec_unit.sv
bench/tb_clock_gen.sv
bench/tb_exec_unit.sv

//--- rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module alu (
    input  exec_pkg::opcode_t opcode,
    input  exec_pkg::funct3_t alu_op,
    input  exec_pkg::funct7_t func7,
    input  exec_pkg::word_t   opA,
    input  exec_pkg::word_t   opB,
    output exec_pkg::word_t   alu_result,
    output logic              zero_flag,
    output logic              err_flag,
    output logic              condJumpValue
);
    import exec_pkg::*;
    import rv_isa_pkg::*;

    operation_t                   alu_control_input;
    logic                         ctrl_err;
    logic signed [`EXEC_XLEN-1:0] opA_signed;
    logic signed [`EXEC_XLEN-1:0] opB_signed;
    shamt_t                       shamt;
    word_t                        op_result;
    logic                         op_cond;
    logic                         is_branch;

    alu_control_unit ctrl (
        .opcode            (opcode),
        .alu_op            (alu_op),
        .func7             (func7),
        .alu_control_input (alu_control_input),
        .ctrl_err          (ctrl_err)
    );

    assign opA_signed = opA;
    assign opB_signed = opB;
    assign shamt      = opB[4:0];   // upper bits of rs2 or imm ignored

    always_comb
    begin
        op_result = '0;   // branches leave the result at zero
        op_cond   = 1'b0;
        case (alu_control_input)
            // register and immediate ops drop the carry out
            ADD:  op_result = opA + opB;
            SUB:  op_result = opA - opB;
            SLL:  op_result = opA << shamt;
            SLT:  op_result = word_t'(opA_signed < opB_signed);
            SLTU: op_result = word_t'(opA < opB);
            XOR:  op_result = opA ^ opB;
            SRL:  op_result = opA >> shamt;
            SRA:  op_result = opA_signed >>> shamt;   // sign fill
            OR:   op_result = opA | opB;
            AND:  op_result = opA & opB;
            // branch compares only drive the jump condition
            BEQ:  op_cond = (opA == opB);
            BNE:  op_cond = (opA != opB);
            BLT:  op_cond = (opA_signed < opB_signed);
            BGE:  op_cond = (opA_signed >= opB_signed);
            BLTU: op_cond = (opA < opB);
            BGEU: op_cond = (opA >= opB);
        endcase
    end

    // an unsupported encoding overrides whatever the datapath produced
    assign alu_result    = ctrl_err ? '0 : op_result;
    assign condJumpValue = ctrl_err ? 1'b0 : op_cond;
    assign err_flag      = ctrl_err;
    assign zero_flag     = (alu_result == '0);   // also set on errors and branches

    assign is_branch = alu_control_input inside {BEQ, BNE, BLT, BGE, BLTU, BGEU};

    always_comb
    begin
        assert (!condJumpValue || is_branch)
        else $error("jump condition raised by a non-branch operation");
    end

endmodule

`default_nettype wire

//--- rtl/alu_control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_control_unit (
    input  logic                   [6:0] opcode,
    input  logic                   [2:0] alu_op,
    input  logic                   [6:0] func7,
    output rv_isa_pkg::operation_t       alu_control_input,
    output logic                         ctrl_err
);
    import rv_isa_pkg::*;

    always_comb
    begin
        alu_control_input = ADD;
        ctrl_err          = 1'b0;
        case (opcode)
            OP:
            begin
                case (alu_op)
                    3'b000:  alu_control_input = (func7 == F7_ALT) ? SUB : ADD;
                    3'b001:  alu_control_input = SLL;
                    3'b010:  alu_control_input = SLT;
                    3'b011:  alu_control_input = SLTU;
                    3'b100:  alu_control_input = XOR;
                    3'b101:  alu_control_input = (func7 == F7_ALT) ? SRA : SRL;
                    3'b110:  alu_control_input = OR;
                    default: alu_control_input = AND;
                endcase
                if (func7 != F7_BASE && func7 != F7_ALT)
                begin
                    alu_control_input = ADD;
                    ctrl_err          = 1'b1;
                end
            end
            OP_IMM:
            begin
                case (alu_op)
                    3'b000:  alu_control_input = ADD;   // ADDI, no subtract form
                    3'b001:
                    begin
                        alu_control_input = SLL;
                        ctrl_err          = (func7 != F7_BASE);
                    end
                    3'b010:  alu_control_input = SLT;
                    3'b011:  alu_control_input = SLTU;
                    3'b100:  alu_control_input = XOR;
                    3'b101:
                    begin
                        // imm[11:5] picks logical or arithmetic right shift
                        alu_control_input = (func7 == F7_ALT) ? SRA : SRL;
                        ctrl_err          = (func7 != F7_BASE && func7 != F7_ALT);
                    end
                    3'b110:  alu_control_input = OR;
                    default: alu_control_input = AND;
                endcase
                if (ctrl_err)
                begin
                    alu_control_input = ADD;
                end
            end
            BRANCH:
            begin
                case (alu_op)
                    3'b000:  alu_control_input = BEQ;
                    3'b001:  alu_control_input = BNE;
                    3'b100:  alu_control_input = BLT;
                    3'b101:  alu_control_input = BGE;
                    3'b110:  alu_control_input = BLTU;
                    3'b111:  alu_control_input = BGEU;
                    default: ctrl_err = 1'b1;   // 010 and 011 are not defined
                endcase
            end
            default: ctrl_err = 1'b1;   // loads, stores, jumps, lui, auipc, ...
        endcase
    end

    // no unknown may escape the decoder for a known encoding
    always_comb
    begin
        if (!$isunknown({opcode, alu_op, func7}))
        begin
            assert (!$isunknown({alu_control_input, ctrl_err}))
            else $error("control unit output unknown for a known encoding");
        end
    end

endmodule

`default_nettype wire

//--- rtl/exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// datapath width in bits
`define EXEC_XLEN 32

// output queue entries, a power of two from 2 upward
`define EXEC_QUEUE_DEPTH 4

`endif

//--- rtl/exec_pkg.sv
`default_nettype none

package exec_pkg;

    `include "exec_cfg.svh"

    // operands, immediate and result all share one width
    typedef logic [`EXEC_XLEN-1:0] word_t;

    typedef logic [4:0] shamt_t;   // low 5 bits of the second operand

    // instruction fields as delivered by the decoder
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

endpackage

`default_nettype wire

//--- rtl/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  exec_pkg::opcode_t opcode,
    input  exec_pkg::funct3_t funct3,
    input  exec_pkg::funct7_t funct7,
    input  exec_pkg::word_t   rs1_val,
    input  exec_pkg::word_t   rs2_val,
    input  exec_pkg::word_t   imm,
    input  logic              out_ready,
    output logic              in_ready,
    output logic              out_valid,
    output exec_pkg::word_t   result,
    output logic              zero,
    output logic              cond_jump,
    output logic              err
);
    import exec_pkg::*;

    logic    stage_valid;
    logic    push_ready;
    opcode_t st_opcode;
    funct3_t st_funct3;
    funct7_t st_funct7;
    word_t   op_a;
    word_t   op_b;
    word_t   alu_result;
    logic    alu_zero;
    logic    alu_err;
    logic    alu_cond;

    operand_stage u_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .opcode      (opcode),
        .funct3      (funct3),
        .funct7      (funct7),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .imm         (imm),
        .advance     (push_ready),   // slot drains whenever the queue takes the result
        .in_ready    (in_ready),
        .stage_valid (stage_valid),
        .op_code     (st_opcode),
        .op_funct3   (st_funct3),
        .op_funct7   (st_funct7),
        .op_a        (op_a),
        .op_b        (op_b)
    );

    alu u_alu (
        .opcode        (st_opcode),
        .alu_op        (st_funct3),
        .func7         (st_funct7),
        .opA           (op_a),
        .opB           (op_b),
        .alu_result    (alu_result),
        .zero_flag     (alu_zero),
        .err_flag      (alu_err),
        .condJumpValue (alu_cond)
    );

    result_queue u_queue (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_valid  (stage_valid),
        .push_result (alu_result),
        .push_zero   (alu_zero),
        .push_cond   (alu_cond),
        .push_err    (alu_err),
        .out_ready   (out_ready),
        .push_ready  (push_ready),
        .out_valid   (out_valid),
        .result      (result),
        .zero        (zero),
        .cond_jump   (cond_jump),
        .err         (err)
    );

endmodule

`default_nettype wire

//--- rtl/operand_stage.sv
`timescale 1ns/1ps
`default_nettype none

module operand_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  exec_pkg::opcode_t opcode,
    input  exec_pkg::funct3_t funct3,
    input  exec_pkg::funct7_t funct7,
    input  exec_pkg::word_t   rs1_val,
    input  exec_pkg::word_t   rs2_val,
    input  exec_pkg::word_t   imm,
    input  logic              advance,
    output logic              in_ready,
    output logic              stage_valid,
    output exec_pkg::opcode_t op_code,
    output exec_pkg::funct3_t op_funct3,
    output exec_pkg::funct7_t op_funct7,
    output exec_pkg::word_t   op_a,
    output exec_pkg::word_t   op_b
);
    import rv_isa_pkg::*;

    logic accept;

    // free slot, or the held entry moves into the queue on this edge
    assign in_ready = !stage_valid || advance;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            stage_valid <= 1'b0;
        end
        else if (accept)
        begin
            stage_valid <= 1'b1;   // refill, possibly in the same edge as the drain
        end
        else if (advance)
        begin
            stage_valid <= 1'b0;
        end
    end

    // payload registers
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            op_code   <= opcode;
            op_funct3 <= funct3;
            op_funct7 <= funct7;
            op_a      <= rs1_val;
            // immediate replaces rs2 only for register-immediate ops
            op_b      <= (opcode == OP_IMM) ? imm : rs2_val;
        end
    end

    // a stalled entry must reach the ALU unchanged
    held_fields_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (stage_valid && !advance) |=> $stable({op_code, op_funct3, op_funct7, op_a, op_b})
    ) else $error("operand slot changed while stalled");

endmodule

`default_nettype wire

//--- rtl/result_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module result_queue (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            push_valid,
    input  exec_pkg::word_t push_result,
    input  logic            push_zero,
    input  logic            push_cond,
    input  logic            push_err,
    input  logic            out_ready,
    output logic            push_ready,
    output logic            out_valid,
    output exec_pkg::word_t result,
    output logic            zero,
    output logic            cond_jump,
    output logic            err
);
    import exec_pkg::*;

    localparam int DEPTH = `EXEC_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W:0] DEPTH_CNT = (PTR_W + 1)'(DEPTH);

    word_t            result_mem [DEPTH];
    logic [2:0]       flag_mem   [DEPTH];   // {zero, cond, err}
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             push;
    logic             pop;

    assign full       = (count == DEPTH_CNT);
    assign out_valid  = (count != '0);
    assign push_ready = !full || out_ready;   // full queue still takes one if the head leaves
    assign push       = push_valid && push_ready;
    assign pop        = out_valid && out_ready;

    // fall-through head
    assign result                  = result_mem[rd_ptr];
    assign {zero, cond_jump, err}  = flag_mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            result_mem[wr_ptr] <= push_result;
            flag_mem[wr_ptr]   <= {push_zero, push_cond, push_err};
        end
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle, or push and pop together
            endcase
        end
    end

    // a push into a full queue only happens alongside a pop
    push_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        (push && full) |=> full
    ) else $error("push into full queue without a matching pop");

    count_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= DEPTH_CNT
    ) else $error("queue occupancy above depth");

endmodule

`default_nettype wire

//--- rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // only these major opcodes are handled by the execute stage
    typedef enum logic [6:0] {
        OP     = 7'b0110011,   // register-register
        OP_IMM = 7'b0010011,   // register-immediate
        BRANCH = 7'b1100011    // conditional branch compare
    } opcode_e;

    // funct7 patterns, also the upper immediate bits of the shift-immediates
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;   // selects SUB and SRA

    // all sixteen codes are used, errors travel on their own signal
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9,
        BEQ  = 4'd10,
        BNE  = 4'd11,
        BLT  = 4'd12,
        BGE  = 4'd13,
        BLTU = 4'd14,
        BGEU = 4'd15
    } operation_t;

endpackage

`default_nettype wire
